//--- design/framer_pkg.sv
`default_nettype none

package framer_pkg;

   // ------------------------------------------------
   // Stream, header and config types
   // ------------------------------------------------

   // One word of the raw packet stream
   typedef struct packed {
      logic [63:0] data;
      logic        last;
   } in_beat_t;

   // One word of the framed stream, tail counts valid bytes of the last beat
   typedef struct packed {
      logic [63:0] data;
      logic        last;
      logic [2:0]  tail;
   } out_beat_t;

   // Fields found in the top half of the first payload beat
   typedef struct packed {
      logic [15:0] flow_id;
      logic [15:0] length;
   } pkt_header_t;

   // Host programmed framing parameters
   typedef struct packed {
      logic [47:0]      mac_dst;
      logic [47:0]      mac_src;
      logic [31:0]      ipv4_dst;
      logic [31:0]      ipv4_src;
      logic [15:0]      udp_src;
      logic [7:0][15:0] udp_dst_table;
      logic [9:0]       udp_dst_base;
      logic             enable;
   } framer_cfg_t;

   // Single cycle register write
   typedef struct packed {
      logic        we;
      logic [4:0]  addr;
      logic [31:0] wdata;
   } csr_write_t;

   // ------------------------------------------------
   // Protocol constants
   // ------------------------------------------------

   localparam logic [15:0] C_ETHERTYPE          = 16'h0800;
   localparam logic [3:0]  C_VERSION            = 4'd4;
   // No IPv4 options, so five words
   localparam logic [3:0]  C_IHL                = 4'd5;
   localparam logic [7:0]  C_DSCP_ECN           = 8'd0;
   localparam logic [15:0] C_IDENTIFICATION     = 16'd0;
   // Don't fragment
   localparam logic [2:0]  C_FLAGS              = 3'b010;
   localparam logic [12:0] C_FRAG_OFFSET        = 13'd0;
   localparam logic [7:0]  C_TTL                = 8'd16;
   // UDP
   localparam logic [7:0]  C_PROTOCOL           = 8'd17;
   localparam logic [15:0] C_UDP_CHECKSUM       = 16'd0;
   localparam logic [15:0] C_IPV4_UDP_HDR_BYTES = 16'd28;
   localparam logic [15:0] C_UDP_HDR_BYTES      = 16'd8;
   localparam int          C_HEADER_BEATS       = 6;

   // Sum of the IPv4 header words that never change
   localparam logic [17:0] C_PRECALC_CHECKSUM =
      18'({C_VERSION, C_IHL, C_DSCP_ECN}) + 18'(C_IDENTIFICATION) +
      18'({C_FLAGS, C_FRAG_OFFSET}) + 18'({C_TTL, C_PROTOCOL});

   // ------------------------------------------------
   // Register map
   // ------------------------------------------------

   localparam logic [4:0] A_MAC_DST_HI   = 5'd0;
   localparam logic [4:0] A_MAC_DST_LO   = 5'd1;
   localparam logic [4:0] A_MAC_SRC_HI   = 5'd2;
   localparam logic [4:0] A_MAC_SRC_LO   = 5'd3;
   localparam logic [4:0] A_IPV4_DST     = 5'd4;
   localparam logic [4:0] A_IPV4_SRC     = 5'd5;
   localparam logic [4:0] A_UDP_SRC      = 5'd6;
   localparam logic [4:0] A_UDP_DST0     = 5'd7;
   localparam logic [4:0] A_UDP_DST1     = 5'd8;
   localparam logic [4:0] A_UDP_DST2     = 5'd9;
   localparam logic [4:0] A_UDP_DST3     = 5'd10;
   localparam logic [4:0] A_UDP_DST4     = 5'd11;
   localparam logic [4:0] A_UDP_DST5     = 5'd12;
   localparam logic [4:0] A_UDP_DST6     = 5'd13;
   localparam logic [4:0] A_UDP_DST7     = 5'd14;
   localparam logic [4:0] A_UDP_DST_BASE = 5'd15;
   // Bit 0 enables framing
   localparam logic [4:0] A_CONTROL      = 5'd16;

endpackage

`default_nettype wire

//--- design/framer_csr.sv
`timescale 1ns/1ps
`default_nettype none

module framer_csr (
   input  wire                      clk,
   input  wire                      rst,
   input  framer_pkg::csr_write_t   wr,
   output framer_pkg::framer_cfg_t  cfg
);

   import framer_pkg::*;

   // ------------------------------------------------
   // Write decode
   // ------------------------------------------------

   // Every register clears on reset, which leaves framing disabled
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg <= '0;
      end else if (wr.we) begin
         case (wr.addr)
            // MAC addresses split as 16 bit high word and 32 bit low word
            A_MAC_DST_HI:   cfg.mac_dst[47:32] <= wr.wdata[15:0];
            A_MAC_DST_LO:   cfg.mac_dst[31:0]  <= wr.wdata;
            A_MAC_SRC_HI:   cfg.mac_src[47:32] <= wr.wdata[15:0];
            A_MAC_SRC_LO:   cfg.mac_src[31:0]  <= wr.wdata;
            // IPv4 addresses are one word each
            A_IPV4_DST:     cfg.ipv4_dst <= wr.wdata;
            A_IPV4_SRC:     cfg.ipv4_src <= wr.wdata;
            A_UDP_SRC:      cfg.udp_src  <= wr.wdata[15:0];
            // Port table for table mode
            A_UDP_DST0:     cfg.udp_dst_table[0] <= wr.wdata[15:0];
            A_UDP_DST1:     cfg.udp_dst_table[1] <= wr.wdata[15:0];
            A_UDP_DST2:     cfg.udp_dst_table[2] <= wr.wdata[15:0];
            A_UDP_DST3:     cfg.udp_dst_table[3] <= wr.wdata[15:0];
            A_UDP_DST4:     cfg.udp_dst_table[4] <= wr.wdata[15:0];
            A_UDP_DST5:     cfg.udp_dst_table[5] <= wr.wdata[15:0];
            A_UDP_DST6:     cfg.udp_dst_table[6] <= wr.wdata[15:0];
            A_UDP_DST7:     cfg.udp_dst_table[7] <= wr.wdata[15:0];
            // Upper ten port bits for direct mode
            A_UDP_DST_BASE: cfg.udp_dst_base <= wr.wdata[9:0];
            A_CONTROL:      cfg.enable <= wr.wdata[0];
            // Unmapped addresses fall through untouched
            default: begin
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/udp_port_map.sv
`timescale 1ns/1ps
`default_nettype none

module udp_port_map (
   input  framer_pkg::pkt_header_t  hdr,
   input  framer_pkg::framer_cfg_t  cfg,
   output logic [15:0]              udp_dst
);

   import framer_pkg::*;

   // Mode select and the two candidate ports
   logic        direct_mode;
   logic [15:0] direct_port;
   logic [15:0] table_port;

   // ------------------------------------------------
   // Flow to port mapping
   // ------------------------------------------------

   // Flow bit 8 picks direct mode
   assign direct_mode = hdr.flow_id[8];

   // Base register on top, low six flow bits below
   assign direct_port = {cfg.udp_dst_base, hdr.flow_id[5:0]};

   // Low three flow bits pick one of the eight table entries
   assign table_port = cfg.udp_dst_table[hdr.flow_id[2:0]];

   always_comb begin
      if (direct_mode) begin
         udp_dst = direct_port;
      end else begin
         udp_dst = table_port;
      end
   end

endmodule

`default_nettype wire

//--- design/ipv4_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum (
   input  wire         clk,
   input  wire         stage_addr,
   input  wire         stage_fold,
   input  wire         stage_final,
   input  wire  [31:0] ipv4_src,
   input  wire  [31:0] ipv4_dst,
   input  wire  [15:0] total_length,
   output logic [15:0] checksum
);

   import framer_pkg::*;

   // Partial sums between the stages
   logic [18:0] sum_addr;
   logic [18:0] sum_addr_len;
   logic [16:0] sum_fold;

   // ------------------------------------------------
   // Stage 1
   // ------------------------------------------------

   // Four address halves plus the constant header words
   always_ff @(posedge clk) begin
      if (stage_addr) begin
         sum_addr <= 19'(ipv4_src[31:16]) + 19'(ipv4_src[15:0]) +
                     19'(ipv4_dst[31:16]) + 19'(ipv4_dst[15:0]) +
                     19'(C_PRECALC_CHECKSUM);
      end
   end

   // ------------------------------------------------
   // Stage 2
   // ------------------------------------------------

   // Nineteen bits still hold the total length without overflow
   assign sum_addr_len = sum_addr + 19'(total_length);

   // Fold the three carry bits back into the low word
   always_ff @(posedge clk) begin
      if (stage_fold) begin
         sum_fold <= 17'(sum_addr_len[15:0]) + 17'(sum_addr_len[18:16]);
      end
   end

   // ------------------------------------------------
   // Stage 3
   // ------------------------------------------------

   // At most one carry left, folding it cannot carry again
   always_ff @(posedge clk) begin
      if (stage_final) begin
         checksum <= ~(sum_fold[15:0] + 16'(sum_fold[16]));
      end
   end

endmodule

`default_nettype wire

//--- design/eth_udp_framer.sv
`timescale 1ns/1ps
`default_nettype none

module eth_udp_framer (
   input  wire                      clk,
   input  wire                      rst,
   input  framer_pkg::framer_cfg_t  cfg,
   input  wire                      in_valid,
   input  framer_pkg::in_beat_t     in_beat,
   output logic                     in_ready,
   output logic                     out_valid,
   output framer_pkg::out_beat_t    out_beat,
   input  wire                      out_ready,
   output logic                     idle
);

   import framer_pkg::*;

   // Idle, one state per header beat, then payload
   typedef enum logic [$clog2(C_HEADER_BEATS + 2)-1:0] {
      S_IDLE,
      S_HDR1,
      S_HDR2,
      S_HDR3,
      S_HDR4,
      S_HDR5,
      S_HDR6,
      S_PAYLOAD
   } state_t;

   state_t      state;
   pkt_header_t hdr;
   // Shared by the IPv4 total length and the UDP length
   logic [15:0] len_q;
   logic [15:0] udp_dst;
   logic [15:0] ip_checksum;

   // ------------------------------------------------
   // State machine
   // ------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         idle  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               // Enable only matters here, a started packet always completes
               if (cfg.enable && in_valid) begin
                  state <= S_HDR1;
               end
               idle <= ~cfg.enable;
            end
            // Header beats advance only when the sink takes them
            S_HDR1: if (out_ready) state <= S_HDR2;
            S_HDR2: if (out_ready) state <= S_HDR3;
            S_HDR3: if (out_ready) state <= S_HDR4;
            S_HDR4: if (out_ready) state <= S_HDR5;
            S_HDR5: if (out_ready) state <= S_HDR6;
            S_HDR6: if (out_ready) state <= S_PAYLOAD;
            S_PAYLOAD: begin
               // Back to idle once the last beat transfers
               if (in_valid && out_ready && in_beat.last) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Peek at the first beat, it stays in place to go out as payload later
   always_ff @(posedge clk) begin
      if (state == S_IDLE && cfg.enable && in_valid) begin
         hdr <= pkt_header_t'(in_beat.data[63:32]);
      end
   end

   // ------------------------------------------------
   // Lengths, port and checksum
   // ------------------------------------------------

   // Total length before beat 3, reloaded with the UDP length before beat 6
   always_ff @(posedge clk) begin
      if (state == S_HDR1) begin
         len_q <= hdr.length + C_IPV4_UDP_HDR_BYTES;
      end else if (state == S_HDR4) begin
         len_q <= hdr.length + C_UDP_HDR_BYTES;
      end
   end

   udp_port_map u_port_map (
      .hdr     (hdr),
      .cfg     (cfg),
      .udp_dst (udp_dst)
   );

   // Stages ride on header beats 1 to 3, result lands before beat 4
   ipv4_checksum u_checksum (
      .clk          (clk),
      .stage_addr   (state == S_HDR1),
      .stage_fold   (state == S_HDR2),
      .stage_final  (state == S_HDR3),
      .ipv4_src     (cfg.ipv4_src),
      .ipv4_dst     (cfg.ipv4_dst),
      .total_length (len_q),
      .checksum     (ip_checksum)
   );

   // ------------------------------------------------
   // Stream handshake and data mux
   // ------------------------------------------------

   // Payload is a straight combinational path from input to output
   always_comb begin
      in_ready  = (state == S_PAYLOAD) ? out_ready : 1'b0;
      out_valid = (state == S_PAYLOAD) ? in_valid : (state != S_IDLE);
      out_beat.last = (state == S_PAYLOAD) ? in_beat.last : 1'b0;
      // Byte count of the final beat, zero when all eight are used
      out_beat.tail = (state == S_PAYLOAD && in_beat.last) ? hdr.length[2:0] : 3'd0;
   end

   always_comb begin
      case (state)
         // Ethernet destination and source
         S_HDR1: out_beat.data = {48'h0, cfg.mac_dst[47:32]};
         S_HDR2: out_beat.data = {cfg.mac_dst[31:0], cfg.mac_src[47:16]};
         // Ethertype, then the first IPv4 word
         S_HDR3: out_beat.data = {cfg.mac_src[15:0], C_ETHERTYPE, C_VERSION, C_IHL,
                                  C_DSCP_ECN, len_q};
         S_HDR4: out_beat.data = {C_IDENTIFICATION, C_FLAGS, C_FRAG_OFFSET, C_TTL,
                                  C_PROTOCOL, ip_checksum};
         S_HDR5: out_beat.data = {cfg.ipv4_src, cfg.ipv4_dst};
         // UDP header with checksum left at zero
         S_HDR6: out_beat.data = {cfg.udp_src, udp_dst, len_q, C_UDP_CHECKSUM};
         default: out_beat.data = in_beat.data;
      endcase
   end

endmodule

`default_nettype wire

//--- design/framer_top.sv
`timescale 1ns/1ps
`default_nettype none

module framer_top (
   input  wire                      clk,
   input  wire                      rst,
   // Host register writes
   input  framer_pkg::csr_write_t   csr_wr,
   // Raw packet stream in
   input  wire                      in_valid,
   input  framer_pkg::in_beat_t     in_beat,
   output logic                     in_ready,
   // Framed packet stream out
   output logic                     out_valid,
   output framer_pkg::out_beat_t    out_beat,
   input  wire                      out_ready,
   output logic                     idle
);

   import framer_pkg::*;

   // Configuration bus from the register file
   framer_cfg_t cfg;

   // ------------------------------------------------
   // Register file
   // ------------------------------------------------

   framer_csr u_csr (
      .clk (clk),
      .rst (rst),
      .wr  (csr_wr),
      .cfg (cfg)
   );

   // ------------------------------------------------
   // Header insertion
   // ------------------------------------------------

   eth_udp_framer u_framer (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat),
      .out_ready (out_ready),
      .idle      (idle)
   );

endmodule

`default_nettype wire

//--- tests/framer_properties.sv
`timescale 1ns/1ps
`default_nettype none

module framer_properties (
   input wire                    clk,
   input wire                    rst,
   input wire                    in_valid,
   input wire                    in_ready,
   input wire                    out_valid,
   input framer_pkg::out_beat_t  out_beat,
   input wire                    out_ready
);

   // Number of failed assertions
   int unsigned assert_errors = 0;
   // Set once an input beat has been offered after reset
   logic        offered;

   always_ff @(posedge clk) begin
      if (rst) begin
         offered <= 1'b0;
      end else if (in_valid) begin
         offered <= 1'b1;
      end
   end

   // --------------------------------------------------
   // Stream rules
   // --------------------------------------------------

   // Stalled beat held until the sink takes it
   stall_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
      else begin
         assert_errors = assert_errors + 1;
         $error("out_beat changed while stalled");
      end

   // During payload ready runs back and valid runs forward unchanged
   ready_follows_sink: assert property (@(posedge clk) disable iff (rst)
      in_ready |-> out_ready && (out_valid == in_valid))
      else begin
         assert_errors = assert_errors + 1;
         $error("in_ready high without out_ready or with out_valid unlike in_valid");
      end

   // Nothing leaves before a packet shows up
   no_early_valid: assert property (@(posedge clk) disable iff (rst)
      !offered |-> !out_valid)
      else begin
         assert_errors = assert_errors + 1;
         $error("out_valid high before any input beat");
      end

endmodule

bind framer_top framer_properties u_props (
   .clk       (clk),
   .rst       (rst),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_beat  (out_beat),
   .out_ready (out_ready)
);

`default_nettype wire

//--- tests/framer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module framer_tb;

   import framer_pkg::*;

   // Roughly four times the beats of all tests, stalls included
   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk;
   logic        rst;
   csr_write_t  csr_wr;
   logic        in_valid;
   in_beat_t    in_beat;
   logic        in_ready;
   logic        out_valid;
   out_beat_t   out_beat;
   logic        out_ready = 1'b0;
   logic        idle;

   // Shadow of the programmed registers for the reference model
   framer_cfg_t model;
   out_beat_t   exp_q[$];
   out_beat_t   got_q[$];
   logic        stall_en;
   logic        gap_en;
   int          cycles = 0;
   int          beat_errors;
   int          port_errors;
   int          flag_errors;
   int          other_errors;
   int          total_errors;

   framer_top UUT (
      .clk       (clk),
      .rst       (rst),
      .csr_wr    (csr_wr),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat),
      .out_ready (out_ready),
      .idle      (idle)
   );

   // --------------------------------------------------
   // Clock, sink, monitor and watchdog
   // --------------------------------------------------

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Sink takes three beats in four when stalls are on
   always @(negedge clk) begin
      if (stall_en) begin
         out_ready = ($urandom % 4) != 0;
      end else begin
         out_ready = 1'b1;
      end
   end

   // Every output beat that transfers
   always @(posedge clk) begin
      if (!rst && out_valid && out_ready) begin
         got_q.push_back(out_beat);
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout, the run did not finish within %0d cycles", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------

   task automatic compare_beat(input string name, input out_beat_t got, input out_beat_t exp);
      if (got !== exp) begin
         beat_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_port(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
      if (got !== exp) begin
         port_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------

   // One's-complement sum of the ten header words, checksum word as zero
   function automatic logic [15:0] ref_checksum(input logic [31:0] src,
                                               input logic [31:0] dst,
                                               input logic [15:0] total);
      logic [31:0] sum;
      sum = 32'h4500 + 32'(total) + 32'h0000 + 32'h4000 + 32'h1011 + 32'h0000 +
            32'(src[31:16]) + 32'(src[15:0]) + 32'(dst[31:16]) + 32'(dst[15:0]);
      while (sum[31:16] != 16'h0) begin
         sum = 32'(sum[15:0]) + 32'(sum[31:16]);
      end
      return ~sum[15:0];
   endfunction

   // Flow bit 8 selects base plus six flow bits, else a table entry
   function automatic logic [15:0] ref_port(input logic [15:0] flow);
      if (flow[8]) begin
         return {model.udp_dst_base, flow[5:0]};
      end
      return model.udp_dst_table[flow[2:0]];
   endfunction

   task automatic expect_header(input logic [15:0] flow, input logic [15:0] length);
      logic [15:0] total;
      logic [63:0] hdr_data[6];
      total = length + 16'd28;
      hdr_data[0] = {48'h0, model.mac_dst[47:32]};
      hdr_data[1] = {model.mac_dst[31:0], model.mac_src[47:16]};
      // Ethertype, version 4, IHL 5, then total length
      hdr_data[2] = {model.mac_src[15:0], 16'h0800, 8'h45, 8'h00, total};
      // DF set, TTL 16, protocol 17
      hdr_data[3] = {16'h0000, 16'h4000, 8'h10, 8'h11,
                     ref_checksum(model.ipv4_src, model.ipv4_dst, total)};
      hdr_data[4] = {model.ipv4_src, model.ipv4_dst};
      hdr_data[5] = {model.udp_src, ref_port(flow), length + 16'd8, 16'h0000};
      for (int i = 0; i < 6; i++) begin
         exp_q.push_back('{data: hdr_data[i], last: 1'b0, tail: 3'd0});
      end
   endtask

   // --------------------------------------------------
   // Drivers
   // --------------------------------------------------

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      @(negedge clk);
      csr_wr = '{we: 1'b1, addr: addr, wdata: data};
      @(negedge clk);
      csr_wr.we = 1'b0;
   endtask

   function automatic framer_cfg_t random_cfg(input logic enable);
      framer_cfg_t c;
      c.mac_dst  = 48'({$urandom, $urandom});
      c.mac_src  = 48'({$urandom, $urandom});
      c.ipv4_dst = $urandom;
      c.ipv4_src = $urandom;
      c.udp_src  = 16'($urandom);
      for (int i = 0; i < 8; i++) begin
         c.udp_dst_table[i] = 16'($urandom);
      end
      c.udp_dst_base = 10'($urandom);
      c.enable       = enable;
      return c;
   endfunction

   // Control goes last so framing starts with a complete config
   task automatic program_cfg(input framer_cfg_t c);
      write_reg(A_MAC_DST_HI, 32'(c.mac_dst[47:32]));
      write_reg(A_MAC_DST_LO, c.mac_dst[31:0]);
      write_reg(A_MAC_SRC_HI, 32'(c.mac_src[47:32]));
      write_reg(A_MAC_SRC_LO, c.mac_src[31:0]);
      write_reg(A_IPV4_DST, c.ipv4_dst);
      write_reg(A_IPV4_SRC, c.ipv4_src);
      write_reg(A_UDP_SRC, 32'(c.udp_src));
      for (int i = 0; i < 8; i++) begin
         write_reg(A_UDP_DST0 + 5'(i), 32'(c.udp_dst_table[i]));
      end
      write_reg(A_UDP_DST_BASE, 32'(c.udp_dst_base));
      write_reg(A_CONTROL, 32'(c.enable));
      model = c;
   endtask

   // First beat carries flow and length in its top half
   task automatic send_packet(input logic [15:0] flow, input logic [15:0] length);
      int       nbeats;
      int       gap;
      in_beat_t beat;
      nbeats = (32'(length) + 7) / 8;
      expect_header(flow, length);
      for (int i = 0; i < nbeats; i++) begin
         beat.data = (i == 0) ? {flow, length, $urandom} : {$urandom, $urandom};
         beat.last = (i == nbeats - 1);
         exp_q.push_back('{data: beat.data, last: beat.last,
                           tail: beat.last ? length[2:0] : 3'd0});
         if (gap_en) begin
            gap = $urandom % 3;
            repeat (gap) begin
               @(negedge clk);
               in_valid = 1'b0;
            end
         end
         @(negedge clk);
         in_valid = 1'b1;
         in_beat  = beat;
         // Held until the beat transfers
         @(posedge clk);
         while (!in_ready) @(posedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_output();
      while (got_q.size() < exp_q.size()) @(posedge clk);
      // Extra cycles so surplus beats show up
      repeat (4) @(posedge clk);
   endtask

   task automatic check_beats(input string name);
      out_beat_t got;
      out_beat_t exp;
      if (got_q.size() != exp_q.size()) begin
         other_errors++;
         $display("%s test received %0d output beats instead of %0d",
                  name, got_q.size(), exp_q.size());
      end
      while (got_q.size() > 0 && exp_q.size() > 0) begin
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         compare_beat({name, " out_beat"}, got, exp);
      end
      got_q.delete();
      exp_q.delete();
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------

   // Four beats, five bytes in the last one
   task automatic test_single();
      program_cfg(random_cfg(1'b1));
      send_packet(16'h0005, 16'd29);
      wait_output();
      check_beats("single");
   endtask

   task automatic test_checksum();
      for (int n = 0; n < 6; n++) begin
         program_cfg(random_cfg(1'b1));
         send_packet(16'($urandom), 16'd8 + 16'($urandom % 57));
         wait_output();
         check_beats("checksum");
      end
   endtask

   // Eight table selectors, then eight random direct flows
   task automatic test_port_map();
      logic [15:0] flow;
      program_cfg(random_cfg(1'b1));
      for (int n = 0; n < 16; n++) begin
         if (n < 8) begin
            flow = (16'($urandom) & 16'hFEF8) | 16'(n);
         end else begin
            flow = 16'($urandom) | 16'h0100;
         end
         send_packet(flow, 16'd12);
         wait_output();
         compare_port("udp_dst", got_q[5].data[47:32], ref_port(flow));
         check_beats("port map");
      end
   endtask

   task automatic test_backpressure();
      program_cfg(random_cfg(1'b1));
      stall_en = 1'b1;
      gap_en   = 1'b1;
      for (int n = 0; n < 5; n++) begin
         send_packet(16'($urandom), 16'd8 + 16'($urandom % 41));
      end
      wait_output();
      stall_en = 1'b0;
      gap_en   = 1'b0;
      check_beats("back-pressure");
   endtask

   // Pending packet waits for enable, then frames normally
   task automatic test_enable();
      program_cfg(random_cfg(1'b0));
      fork
         send_packet(16'h0003, 16'd20);
         begin
            repeat (3) @(posedge clk);
            repeat (8) begin
               @(posedge clk);
               compare_flag("out_valid", out_valid, 1'b0);
               compare_flag("idle", idle, 1'b1);
            end
            write_reg(A_CONTROL, 32'd1);
            while (!out_valid) @(posedge clk);
            compare_flag("idle", idle, 1'b0);
         end
      join
      wait_output();
      check_beats("enable");
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------

   initial begin
      void'($urandom(2));
      rst          = 1'b1;
      csr_wr       = '0;
      in_valid     = 1'b0;
      in_beat      = '0;
      stall_en     = 1'b0;
      gap_en       = 1'b0;
      model        = '0;
      beat_errors  = 0;
      port_errors  = 0;
      flag_errors  = 0;
      other_errors = 0;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      // Outputs straight after reset
      compare_flag("out_valid", out_valid, 1'b0);
      compare_flag("in_ready", in_ready, 1'b0);
      compare_flag("idle", idle, 1'b0);

      test_single();
      test_checksum();
      test_port_map();
      test_backpressure();
      test_enable();

      total_errors = beat_errors + port_errors + flag_errors + other_errors +
                     int'(UUT.u_props.assert_errors);
      $display("Errors: beat %0d, port %0d, flag %0d, other %0d, assertion %0d",
               beat_errors, port_errors, flag_errors, other_errors,
               UUT.u_props.assert_errors);
      if (total_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
design/framer_pkg.sv
design/framer_csr.sv
design/udp_port_map.sv
design/ipv4_checksum.sv
design/eth_udp_framer.sv
design/framer_top.sv
tests/framer_properties.sv
tests/framer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the framer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module framer_tb -f project.f -o framer_sim

# Run to the end even on assertion errors so the report line is written
status=0
./obj_dir/framer_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi
